//--- hw/hisCfgPkg.sv
package hisCfgPkg;

    // timestamp layout
    // raw arrival time in tdc ticks
    localparam int TS_WIDTH = 10;

    // histogram geometry
    // 3 index bits per histogram
    localparam int BIN_BITS = 3;
    // same bin count for coarse and fine pass
    localparam int NUM_BINS = 1 << BIN_BITS;

    // bin counter width
    localparam int COUNT_WIDTH = 8;
    // largest value a bin counter can hold
    localparam int COUNT_MAX = (1 << COUNT_WIDTH) - 1;

    // coarse bin = top BIN_BITS of the timestamp
    // log2 of coarse bin width, 7 -> 128 ticks
    localparam int COARSE_SHIFT = TS_WIDTH - BIN_BITS;
    // ticks covered by one coarse bin
    localparam int COARSE_SPAN = 1 << COARSE_SHIFT;

    // fine bins split one coarse bin into NUM_BINS parts
    // log2 of fine bin width, 4 -> 16 ticks
    localparam int FINE_SHIFT = COARSE_SHIFT - BIN_BITS;

endpackage

//--- hw/hisTypesPkg.sv
package hisTypesPkg;

    // timestamp or window bound
    typedef logic [hisCfgPkg::TS_WIDTH-1:0] timestampT;

    // index into one histogram
    typedef logic [hisCfgPkg::BIN_BITS-1:0] binIdxT;

    // hit count of a single bin
    typedef logic [hisCfgPkg::COUNT_WIDTH-1:0] countT;

    // sequencer phases
    // COARSE_ACQ   collect samples into the coarse histogram
    // COARSE_SCAN  peak search over coarse bins
    // FINE_ACQ     collect in-window samples into the fine histogram
    // FINE_SCAN    peak search over fine bins
    // REPORT       one cycle result strobe, arrays cleared
    typedef enum logic [2:0] {
        COARSE_ACQ,
        COARSE_SCAN,
        FINE_ACQ,
        FINE_SCAN,
        REPORT
    } seqStateT;

endpackage

//--- hw/hisBinArray.sv
`timescale 1ns/1ps

module hisBinArray (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clear,
    input  logic                 incEn,
    input  hisTypesPkg::binIdxT  incBin,
    input  logic                 scanStart,
    output hisTypesPkg::binIdxT  peakBin,
    output logic                 peakDone
);

    // index of the last bin visited by the walk
    localparam hisTypesPkg::binIdxT lastIdx = hisTypesPkg::binIdxT'(hisCfgPkg::NUM_BINS - 1);

    // one counter per bin
    hisTypesPkg::countT binCnt [hisCfgPkg::NUM_BINS];

    // walk state
    logic                scanning;
    hisTypesPkg::binIdxT scanIdx;

    // running best of the walk
    hisTypesPkg::countT  maxCnt;
    hisTypesPkg::binIdxT maxIdx;

    // bin under inspection this cycle
    hisTypesPkg::countT  curCnt;
    logic                curWins;
    logic                scanLast;

    assign curCnt   = binCnt[scanIdx];
    // strictly greater, so the lower index keeps a tie
    assign curWins  = curCnt > maxCnt;
    assign scanLast = scanIdx == lastIdx;

    // counter bank
    // clear wins over an increment in the same cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < hisCfgPkg::NUM_BINS; i++) begin
                binCnt[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < hisCfgPkg::NUM_BINS; i++) begin
                binCnt[i] <= '0;
            end
        end else if (incEn) begin
            binCnt[incBin] <= binCnt[incBin] + hisTypesPkg::countT'(1);
        end
    end

    // walk control
    // scanStart edge arms the walk, then one bin per cycle
    // peakDone lands NUM_BINS+1 cycles after scanStart
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scanning <= 1'b0;
            scanIdx  <= '0;
            peakDone <= 1'b0;
            peakBin  <= '0;
        end else begin
            peakDone <= 1'b0;
            if (scanStart) begin
                scanning <= 1'b1;
                scanIdx  <= '0;
            end else if (scanning) begin
                if (scanLast) begin
                    scanning <= 1'b0;
                    peakDone <= 1'b1;
                    // last bin may still take the lead
                    peakBin  <= curWins ? scanIdx : maxIdx;
                end else begin
                    scanIdx <= scanIdx + hisTypesPkg::binIdxT'(1);
                end
            end
        end
    end

    // running maximum
    // zero start means an empty histogram reports bin 0
    always_ff @(posedge clk) begin
        if (scanStart) begin
            maxCnt <= '0;
            maxIdx <= '0;
        end else if (scanning && curWins) begin
            maxCnt <= curCnt;
            maxIdx <= scanIdx;
        end
    end

    // sequencer must hold off increments until the walk has finished
    aNoIncDuringScan : assert property (
        @(posedge clk) disable iff (!rstN)
        scanning |-> !incEn
    ) else $error("bin increment during peak search");

    // samples per histogram is sized so a bin never wraps
    aNoCountWrap : assert property (
        @(posedge clk) disable iff (!rstN)
        incEn |-> (binCnt[incBin] != hisTypesPkg::countT'(hisCfgPkg::COUNT_MAX))
    ) else $error("bin counter overflow on bin %0d", incBin);

endmodule

//--- hw/hisSequencer.sv
`timescale 1ns/1ps

module hisSequencer #(
    parameter int samplesPerHis = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wrEn,
    input  hisTypesPkg::timestampT roughData,
    input  hisTypesPkg::binIdxT    coarsePeakBin,
    input  hisTypesPkg::binIdxT    finePeakBin,
    input  logic                   coarseDone,
    input  logic                   fineDone,
    output logic                   coarseInc,
    output logic                   fineInc,
    output hisTypesPkg::binIdxT    coarseIncBin,
    output hisTypesPkg::binIdxT    fineIncBin,
    output logic                   coarseScanStart,
    output logic                   fineScanStart,
    output logic                   clear,
    output logic                   busy,
    output logic                   resultValid,
    output hisTypesPkg::binIdxT    peakCH,
    output hisTypesPkg::binIdxT    peakFH,
    output hisTypesPkg::timestampT thMinus,
    output hisTypesPkg::timestampT thPositive,
    output hisTypesPkg::timestampT peakTime
);

    // upper bound offset of the window, 127
    localparam hisTypesPkg::timestampT coarseSpanM1 =
        hisTypesPkg::timestampT'(hisCfgPkg::COARSE_SPAN - 1);
    // sample count value on the last sample of a phase
    localparam hisTypesPkg::countT lastCnt = hisTypesPkg::countT'(samplesPerHis - 1);

    hisTypesPkg::seqStateT state;
    hisTypesPkg::countT    sampleCnt;

    // window from the coarse pass
    hisTypesPkg::binIdxT    chPeak;
    hisTypesPkg::timestampT winLo;
    hisTypesPkg::timestampT winHi;

    logic                   accept;
    logic                   acqDone;
    logic                   inWindow;
    hisTypesPkg::timestampT coarseBase;
    hisTypesPkg::timestampT winOffset;
    hisTypesPkg::timestampT fineTime;

    // scans and report block new samples
    assign busy = state inside {hisTypesPkg::COARSE_SCAN, hisTypesPkg::FINE_SCAN,
                                hisTypesPkg::REPORT};

    // only ACQ states leave busy low
    assign accept  = wrEn && !busy;
    assign acqDone = accept && (sampleCnt == lastCnt);

    // coarse mapping
    // top BIN_BITS of the timestamp
    assign coarseInc    = accept && (state == hisTypesPkg::COARSE_ACQ);
    assign coarseIncBin = hisTypesPkg::binIdxT'(roughData >> hisCfgPkg::COARSE_SHIFT);

    // fine mapping
    // inclusive window, offset from the lower bound in 16 tick steps
    assign inWindow   = (roughData >= winLo) && (roughData <= winHi);
    assign winOffset  = roughData - winLo;
    assign fineInc    = accept && (state == hisTypesPkg::FINE_ACQ) && inWindow;
    assign fineIncBin = hisTypesPkg::binIdxT'(winOffset >> hisCfgPkg::FINE_SHIFT);

    // lower bound of the coarse peak bin
    assign coarseBase = hisTypesPkg::timestampT'(coarsePeakBin) << hisCfgPkg::COARSE_SHIFT;

    // start of the winning fine bin
    assign fineTime = winLo + (hisTypesPkg::timestampT'(finePeakBin) << hisCfgPkg::FINE_SHIFT);

    // accepted samples of the current phase
    // out-of-window fine samples count here too
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sampleCnt <= '0;
        end else if (accept) begin
            sampleCnt <= (sampleCnt == lastCnt) ? '0 : sampleCnt + hisTypesPkg::countT'(1);
        end
    end

    // window latch on the coarse peak
    always_ff @(posedge clk) begin
        if (state == hisTypesPkg::COARSE_SCAN && coarseDone) begin
            chPeak <= coarsePeakBin;
            winLo  <= coarseBase;
            winHi  <= coarseBase + coarseSpanM1;
        end
    end

    // phase FSM
    // strobes default low, high for one cycle when set
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state           <= hisTypesPkg::COARSE_ACQ;
            coarseScanStart <= 1'b0;
            fineScanStart   <= 1'b0;
            clear           <= 1'b0;
            resultValid     <= 1'b0;
            peakCH          <= '0;
            peakFH          <= '0;
            thMinus         <= '0;
            thPositive      <= '0;
            peakTime        <= '0;
        end else begin
            coarseScanStart <= 1'b0;
            fineScanStart   <= 1'b0;
            clear           <= 1'b0;
            resultValid     <= 1'b0;
            case (state)
                hisTypesPkg::COARSE_ACQ: begin
                    if (acqDone) begin
                        coarseScanStart <= 1'b1;
                        state           <= hisTypesPkg::COARSE_SCAN;
                    end
                end
                hisTypesPkg::COARSE_SCAN: begin
                    if (coarseDone) begin
                        state <= hisTypesPkg::FINE_ACQ;
                    end
                end
                hisTypesPkg::FINE_ACQ: begin
                    if (acqDone) begin
                        fineScanStart <= 1'b1;
                        state         <= hisTypesPkg::FINE_SCAN;
                    end
                end
                hisTypesPkg::FINE_SCAN: begin
                    // results move to the outputs together with the strobe
                    if (fineDone) begin
                        resultValid <= 1'b1;
                        clear       <= 1'b1;
                        peakCH      <= chPeak;
                        peakFH      <= finePeakBin;
                        thMinus     <= winLo;
                        thPositive  <= winHi;
                        peakTime    <= fineTime;
                        state       <= hisTypesPkg::REPORT;
                    end
                end
                hisTypesPkg::REPORT: begin
                    // arrays are zeroed at the end of this cycle
                    state <= hisTypesPkg::COARSE_ACQ;
                end
                default: begin
                    state <= hisTypesPkg::COARSE_ACQ;
                end
            endcase
        end
    end

    // one pulse per histogram pair, the arrays are idle right after it
    aSingleResult : assert property (
        @(posedge clk) disable iff (!rstN)
        resultValid |=> !resultValid
    ) else $error("resultValid held for more than one cycle");

    // sample budget must fit the sample counter and the bin counters
    aSamplesFit : assert property (
        @(posedge clk) disable iff (!rstN)
        (samplesPerHis >= 1) && (samplesPerHis <= hisCfgPkg::COUNT_MAX)
    ) else $error("samplesPerHis %0d does not fit a bin count", samplesPerHis);

endmodule

//--- hw/hisBuilderTop.sv
`timescale 1ns/1ps

module hisBuilderTop #(
    parameter int samplesPerHis = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wrEn,
    input  hisTypesPkg::timestampT roughData,
    output logic                   busy,
    output logic                   resultValid,
    output hisTypesPkg::binIdxT    peakCH,
    output hisTypesPkg::binIdxT    peakFH,
    output hisTypesPkg::timestampT thMinus,
    output hisTypesPkg::timestampT thPositive,
    output hisTypesPkg::timestampT peakTime
);

    // coarse histogram nets
    logic                coarseInc;
    hisTypesPkg::binIdxT coarseIncBin;
    logic                coarseScanStart;
    hisTypesPkg::binIdxT coarsePeakBin;
    logic                coarseDone;

    // fine histogram nets
    logic                fineInc;
    hisTypesPkg::binIdxT fineIncBin;
    logic                fineScanStart;
    hisTypesPkg::binIdxT finePeakBin;
    logic                fineDone;

    // shared by both arrays
    logic clear;

    // phase control, window and fine mapping
    hisSequencer #(
        .samplesPerHis (samplesPerHis)
    ) hisSequencer_i (
        .clk             (clk),
        .rstN            (rstN),
        .wrEn            (wrEn),
        .roughData       (roughData),
        .coarsePeakBin   (coarsePeakBin),
        .finePeakBin     (finePeakBin),
        .coarseDone      (coarseDone),
        .fineDone        (fineDone),
        .coarseInc       (coarseInc),
        .fineInc         (fineInc),
        .coarseIncBin    (coarseIncBin),
        .fineIncBin      (fineIncBin),
        .coarseScanStart (coarseScanStart),
        .fineScanStart   (fineScanStart),
        .clear           (clear),
        .busy            (busy),
        .resultValid     (resultValid),
        .peakCH          (peakCH),
        .peakFH          (peakFH),
        .thMinus         (thMinus),
        .thPositive      (thPositive),
        .peakTime        (peakTime)
    );

    // coarse histogram, 128 ticks per bin
    hisBinArray coarseHis_i (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .incEn     (coarseInc),
        .incBin    (coarseIncBin),
        .scanStart (coarseScanStart),
        .peakBin   (coarsePeakBin),
        .peakDone  (coarseDone)
    );

    // fine histogram, 16 ticks per bin inside the window
    hisBinArray fineHis_i (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .incEn     (fineInc),
        .incBin    (fineIncBin),
        .scanStart (fineScanStart),
        .peakBin   (finePeakBin),
        .peakDone  (fineDone)
    );

endmodule

//--- sim/hisBuilderTb.sv
`timescale 1ns/1ps

module hisBuilderTb;

    // clock period in ns
    localparam int clkPeriod = 20;
    // three directed histograms plus twenty random ones
    localparam int numDirected = 3;
    localparam int numRandom = 20;
    localparam int numHis = numDirected + numRandom;
    // 8 coarse and 8 fine samples per histogram
    localparam int samplesPerHis = 8;
    localparam int samplesTotal = numHis * 2 * samplesPerHis;
    // 40 cycles per sample plus a margin
    localparam int watchdogNs = (samplesTotal * 40 + 200) * clkPeriod;

    logic                   clk;
    logic                   rstN;
    logic                   wrEn;
    hisTypesPkg::timestampT roughData;
    logic                   busy;
    logic                   resultValid;
    hisTypesPkg::binIdxT    peakCH;
    hisTypesPkg::binIdxT    peakFH;
    hisTypesPkg::timestampT thMinus;
    hisTypesPkg::timestampT thPositive;
    hisTypesPkg::timestampT peakTime;

    int seed = 83;

    // sample values of the histogram being sent
    int coarseSamp [8];
    int fineSamp [8];

    // expected results, packed as {ch, fh, thMinus, thPositive, peakTime}
    logic [35:0] expQ [$];
    int resultCount = 0;

    hisBuilderTop #(
        .samplesPerHis (samplesPerHis)
    ) hisBuilderTop_i (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .roughData   (roughData),
        .busy        (busy),
        .resultValid (resultValid),
        .peakCH      (peakCH),
        .peakFH      (peakFH),
        .thMinus     (thMinus),
        .thPositive  (thPositive),
        .peakTime    (peakTime)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // compare one output against its expected value
    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("FAIL time %0t %s expected %0d actual %0d", $time, name, expVal, actVal);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // coarse peak of the stored coarse samples
    // bin = sample / 128, lowest index wins a tie
    function automatic int refCoarse();
        int cnt [8];
        int best;
        for (int i = 0; i < 8; i++) begin
            cnt[i] = 0;
        end
        for (int i = 0; i < 8; i++) begin
            cnt[coarseSamp[i] / 128]++;
        end
        best = 0;
        for (int i = 1; i < 8; i++) begin
            if (cnt[i] > cnt[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    // full result of one histogram pair
    function automatic logic [35:0] refPeak();
        int cnt [8];
        int ch;
        int fh;
        int lo;
        int hi;
        int pt;
        ch = refCoarse();
        lo = ch * 128;
        hi = lo + 127;
        for (int i = 0; i < 8; i++) begin
            cnt[i] = 0;
        end
        // out-of-window samples add nothing
        for (int i = 0; i < 8; i++) begin
            if (fineSamp[i] >= lo && fineSamp[i] <= hi) begin
                cnt[(fineSamp[i] - lo) / 16]++;
            end
        end
        fh = 0;
        for (int i = 1; i < 8; i++) begin
            if (cnt[i] > cnt[fh]) begin
                fh = i;
            end
        end
        pt = lo + fh * 16;
        return {ch[2:0], fh[2:0], lo[9:0], hi[9:0], pt[9:0]};
    endfunction

    // junk rides on wrEn while busy, then the real sample goes in
    task automatic offerSample(input int value);
        while (busy) begin
            wrEn      = 1'b1;
            roughData = $random(seed);
            @(posedge clk);
            #2;
        end
        wrEn      = 1'b1;
        roughData = value;
        @(posedge clk);
        #2;
        wrEn = 1'b0;
    endtask

    // queue the expectation, then both passes
    task automatic sendHis();
        expQ.push_back(refPeak());
        for (int i = 0; i < 8; i++) begin
            offerSample(coarseSamp[i]);
        end
        for (int i = 0; i < 8; i++) begin
            offerSample(fineSamp[i]);
        end
    endtask

    // clustered random values so the peaks are not all at bin 0
    task automatic buildRandom();
        int center;
        int base;
        center = $random(seed) & 7;
        for (int i = 0; i < 8; i++) begin
            if ($random(seed) & 1) begin
                coarseSamp[i] = center * 128 + ($random(seed) & 127);
            end else begin
                coarseSamp[i] = $random(seed) & 1023;
            end
        end
        base = refCoarse() * 128;
        // mostly in window, some strays
        for (int i = 0; i < 8; i++) begin
            if (($random(seed) & 3) != 0) begin
                fineSamp[i] = base + ($random(seed) & 127);
            end else begin
                fineSamp[i] = $random(seed) & 1023;
            end
        end
    endtask

    // checker, samples on the falling edge where outputs are settled
    initial begin
        logic [35:0] exp;
        forever begin
            @(negedge clk);
            if (resultValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("result pulse arrived with no histogram pending");
                    $display("Test failed");
                    $fatal(1);
                end
                exp = expQ.pop_front();
                // report cycle still counts as busy
                checkValue("busy", 1, busy);
                checkValue("peakCH", exp[35:33], peakCH);
                checkValue("peakFH", exp[32:30], peakFH);
                checkValue("thMinus", exp[29:20], thMinus);
                checkValue("thPositive", exp[19:10], thPositive);
                checkValue("peakTime", exp[9:0], peakTime);
                resultCount++;
            end
        end
    end

    // watchdog
    initial begin
        #(watchdogNs);
        $display("no result arrived before the time limit");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        rstN      = 1'b0;
        wrEn      = 1'b0;
        roughData = '0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        // idle outputs after reset
        @(negedge clk);
        checkValue("busy", 0, busy);
        checkValue("resultValid", 0, resultValid);
        checkValue("peakCH", 0, peakCH);
        checkValue("peakFH", 0, peakFH);
        checkValue("thMinus", 0, thMinus);
        checkValue("thPositive", 0, thPositive);
        checkValue("peakTime", 0, peakTime);
        @(posedge clk);
        #2;

        // clear coarse peak at bin 0, fine cluster near 90
        coarseSamp = '{108, 90, 90, 90, 300, 95, 700, 60};
        fineSamp   = '{90, 92, 95, 100, 85, 120, 40, 91};
        sendHis();

        // coarse tie between bins 2 and 5
        coarseSamp = '{300, 310, 650, 660, 320, 700, 330, 710};
        fineSamp   = '{260, 290, 295, 700, 380, 300, 5, 383};
        sendHis();

        // window 768..895, every fine sample outside it
        coarseSamp = '{800, 810, 890, 770, 100, 850, 768, 895};
        fineSamp   = '{10, 200, 1000, 500, 900, 767, 896, 0};
        sendHis();

        for (int h = 0; h < numRandom; h++) begin
            buildRandom();
            sendHis();
        end

        wrEn = 1'b0;
        wait (resultCount == numHis);
        repeat (4) @(posedge clk);
        #2;
        // back in coarse acquisition once the report cycle is over
        if (busy === 1'b0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("DUT still busy after the last result");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- project.f
hw/hisCfgPkg.sv
hw/hisTypesPkg.sv
hw/hisBinArray.sv
hw/hisSequencer.sv
hw/hisBuilderTop.sv
sim/hisBuilderTb.sv
